// ==== source/ubaPkg.sv ====
`default_nettype none

package ubaPkg;

   //////////////////////////////////////////////////////////////////////
   // Bus widths
   //////////////////////////////////////////////////////////////////////

   // Unibus address, 18 bits
   typedef logic [17:0] ubaAddr_t;

   // One data word on the bus
   typedef logic [15:0] ubaData_t;

   // Interrupt request lines, bit 3 wins
   typedef logic [3:0] ubaIrq_t;

   //////////////////////////////////////////////////////////////////////
   // Address map
   //////////////////////////////////////////////////////////////////////

   // Adapter's own registers
   localparam ubaAddr_t UbaStatusAddr = 18'h3_F100;
   localparam ubaAddr_t UbaMaskAddr   = 18'h3_F102;

   // Device window, both ends included
   localparam ubaAddr_t DevBase = 18'h3_E000;
   localparam ubaAddr_t DevLast = 18'h3_E0FF;

   // Status register layout
   // Sticky NXD flag, write 1 to clear
   localparam int StatusNxdBit  = 15;
   // Read-only mirror of the pending lines
   localparam int StatusPendLsb = 0;

   // NXD machine states
   typedef enum logic [1:0] {
      nxdIdle,
      nxdWait,
      nxdFlag,
      nxdAck
   } nxdState_t;

endpackage

`default_nettype wire

// ==== source/ubaReqIf.sv ====
`default_nettype none

// Decoded cycle requests and the matching acknowledges
interface ubaReqIf;

   // Bus request as seen by the adapter
   logic busReq;

   // One request per target
   logic ubaReq;
   logic devReq;
   logic wruReq;

   // Acknowledge levels from each target
   logic ubaAck;
   logic devAck;
   logic wruAck;

   // Decoder drives the requests
   // Device acknowledge also enters here
   modport decode (output busReq, ubaReq, devReq, wruReq, devAck);

   // Timeout machine watches everything
   modport nxd (input busReq, ubaReq, devReq, wruReq, ubaAck, devAck, wruAck);

   // Register block
   modport regs (input ubaReq, output ubaAck);

   // Interrupt responder
   modport wru (input wruReq, output wruAck);

endinterface

`default_nettype wire

// ==== source/ubaBusIf.sv ====
`default_nettype none

module ubaBusIf
(
   input  wire logic            busReq,
   input  wire logic            busWrite,
   input  wire logic            busWru,
   input  wire ubaPkg::ubaAddr_t busAddr,
   input  wire ubaPkg::ubaData_t regData,
   input  wire ubaPkg::ubaData_t devData,
   input  wire ubaPkg::ubaData_t wruData,
   input  wire logic            devAckIn,
   input  wire logic            busAckIn,
   output      logic            devReq,
   output      logic            busAck,
   output      ubaPkg::ubaData_t busDataOut,
   ubaReqIf.decode              rq
);

   import ubaPkg::*;

   //////////////////////////////////////////////////////////////////////
   // Address decode
   //////////////////////////////////////////////////////////////////////

   logic isReg;
   logic isDev;
   logic ubaSel;
   logic devSel;
   logic wruSel;

   // Either of the two adapter registers
   assign isReg = (busAddr == UbaStatusAddr) || (busAddr == UbaMaskAddr);

   // Inclusive device window
   assign isDev = (busAddr >= DevBase) && (busAddr <= DevLast);

   // WRU takes priority over any address
   assign wruSel = busReq & busWru;
   assign ubaSel = busReq & ~busWru & isReg;
   // Registers shadow the device window
   assign devSel = busReq & ~busWru & ~isReg & isDev;

   // Unmapped addresses raise nothing here
   // The NXD machine times them out as device cycles

   assign rq.busReq = busReq;
   assign rq.wruReq = wruSel;
   assign rq.ubaReq = ubaSel;
   assign rq.devReq = devSel;

   // Device acknowledge goes in as is
   assign rq.devAck = devAckIn;

   // Device request level toward the port
   // Write flag reaches the device straight from the top level
   assign devReq = devSel;

   //////////////////////////////////////////////////////////////////////
   // Read data and acknowledge back to the master
   //////////////////////////////////////////////////////////////////////

   // Same decode picks the returned word
   always_comb
   begin
      if (wruSel)
         busDataOut = wruData;
      else if (ubaSel)
         busDataOut = regData;
      else if (devSel)
         busDataOut = devData;
      else
         busDataOut = '0;
   end

   // Acknowledge drops as soon as the master lets go
   assign busAck = busAckIn & busReq;

endmodule

`default_nettype wire

// ==== source/ubaNxd.sv ====
`default_nettype none

module ubaNxd
#(
   parameter int NxdTimeout = 10
)
(
   input  wire logic clk,
   input  wire logic rst,
   ubaReqIf.nxd      rq,
   output      logic busAckOut,
   output      logic setNxd
);

   import ubaPkg::*;

   // Counter wide enough to hold the load value
   localparam int CntW = $clog2(NxdTimeout + 1);

   nxdState_t      state;
   logic           isUba;
   logic [CntW-1:0] cnt;
   logic           ubaHit;
   logic           devHit;
   logic           ackHit;

   // Device acknowledge only counts while it is asked for
   assign devHit = rq.devReq & rq.devAck;
   assign ubaHit = rq.ubaReq & rq.ubaAck;

   // Acknowledge of the remembered target
   assign ackHit = isUba ? ubaHit : devHit;

   //////////////////////////////////////////////////////////////////////
   // Timeout FSM
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state <= nxdIdle;
         isUba <= 1'b0;
         cnt   <= '0;
      end
      else
      begin
         unique case (state)
            nxdIdle:
            begin
               // WRU cycles are never timed
               if (rq.busReq & rq.wruReq)
               begin
                  if (rq.wruAck)
                     state <= nxdAck;
               end
               // Register or device cycle, unmapped counts as device
               else if (rq.busReq)
               begin
                  isUba <= rq.ubaReq;
                  cnt   <= CntW'(NxdTimeout - 1);
                  if (rq.ubaReq ? ubaHit : devHit)
                     state <= nxdAck;
                  else
                     state <= nxdWait;
               end
            end

            nxdWait:
            begin
               if (ackHit)
                  state <= nxdAck;
               // Last count used up
               else if (cnt == '0)
                  state <= nxdFlag;
               else
                  cnt <= cnt - 1'b1;
            end

            // One cycle only, drives the status set
            nxdFlag:
               state <= nxdIdle;

            // Wait for the master to release
            nxdAck:
               if (!rq.busReq)
                  state <= nxdIdle;

            default:
               state <= nxdIdle;
         endcase
      end
   end

   assign setNxd    = (state == nxdFlag);
   assign busAckOut = (state == nxdAck) & rq.busReq;

endmodule

`default_nettype wire

// ==== source/ubaRegs.sv ====
`default_nettype none

module ubaRegs
(
   input  wire logic            clk,
   input  wire logic            rst,
   ubaReqIf.regs                rq,
   input  wire logic            busWrite,
   input  wire ubaPkg::ubaAddr_t busAddr,
   input  wire ubaPkg::ubaData_t busDataIn,
   input  wire logic            setNxd,
   input  wire ubaPkg::ubaIrq_t  pend,
   output      ubaPkg::ubaIrq_t  mask,
   output      ubaPkg::ubaData_t regData
);

   import ubaPkg::*;

   localparam int IrqW = $bits(ubaIrq_t);

   logic ackReg;
   logic nxdBit;
   logic wrStrobe;
   logic wrStatus;
   logic wrMask;
   logic clrNxd;

   //////////////////////////////////////////////////////////////////////
   // Register acknowledge
   //////////////////////////////////////////////////////////////////////

   // One cycle behind the request, both edges
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         ackReg <= 1'b0;
      else
         ackReg <= rq.ubaReq;
   end

   assign rq.ubaAck = ackReg;

   // Write lands once, in the first cycle of the request
   assign wrStrobe = rq.ubaReq & ~ackReg & busWrite;
   assign wrStatus = wrStrobe & (busAddr == UbaStatusAddr);
   assign wrMask   = wrStrobe & (busAddr == UbaMaskAddr);

   // Write 1 to clear
   assign clrNxd = wrStatus & busDataIn[StatusNxdBit];

   //////////////////////////////////////////////////////////////////////
   // Status and mask
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         nxdBit <= 1'b0;
         mask   <= '0;
      end
      else
      begin
         // Timeout beats a simultaneous clear
         if (setNxd)
            nxdBit <= 1'b1;
         else if (clrNxd)
            nxdBit <= 1'b0;

         if (wrMask)
            mask <= busDataIn[IrqW-1:0];
      end
   end

   // Read mux on address alone
   always_comb
   begin
      regData = '0;
      if (busAddr == UbaStatusAddr)
      begin
         regData[StatusNxdBit] = nxdBit;
         regData[StatusPendLsb +: IrqW] = pend;
      end
      else if (busAddr == UbaMaskAddr)
         regData[IrqW-1:0] = mask;
   end

endmodule

`default_nettype wire

// ==== source/ubaWru.sv ====
`default_nettype none

module ubaWru
(
   ubaReqIf.wru                 rq,
   input  wire ubaPkg::ubaIrq_t  irq,
   input  wire ubaPkg::ubaIrq_t  mask,
   output      ubaPkg::ubaData_t wruData
);

   import ubaPkg::*;

   ubaIrq_t masked;
   ubaIrq_t oneHot;

   //////////////////////////////////////////////////////////////////////
   // Priority answer
   //////////////////////////////////////////////////////////////////////

   // Only enabled lines take part
   assign masked = irq & mask;

   // Scan upward so the highest set line is kept
   always_comb
   begin
      oneHot = '0;
      for (int i = 0; i < $bits(ubaIrq_t); i++)
      begin
         if (masked[i])
            oneHot = ubaIrq_t'(1) << i;
      end
   end

   // Zero-extended onto the data bus
   assign wruData = ubaData_t'(oneHot);

   // Nothing enabled and pending means no answer at all
   // The master then waits forever, no timeout on WRU
   assign rq.wruAck = rq.wruReq & (oneHot != '0);

endmodule

`default_nettype wire

// ==== source/uba.sv ====
`default_nettype none

module uba
#(
   parameter int NxdTimeout = 10
)
(
   input  wire logic            clk,
   input  wire logic            rst,
   input  wire logic            busReq,
   input  wire logic            busWrite,
   input  wire logic            busWru,
   input  wire ubaPkg::ubaAddr_t busAddr,
   input  wire ubaPkg::ubaData_t busDataIn,
   output      ubaPkg::ubaData_t busDataOut,
   output      logic            busAck,
   output      logic            devReq,
   input  wire logic            devAck,
   input  wire ubaPkg::ubaData_t devData,
   input  wire ubaPkg::ubaIrq_t  irq
);

   import ubaPkg::*;

   // Internal request bundle
   ubaReqIf rq();

   ubaData_t regData;
   ubaData_t wruData;
   ubaIrq_t  mask;
   logic     busAckInt;
   logic     setNxd;

   //////////////////////////////////////////////////////////////////////
   // Decode and return path
   //////////////////////////////////////////////////////////////////////

   // Device sees busWrite, busAddr and busDataIn directly
   ubaBusIf busIf (
      .busReq     (busReq),
      .busWrite   (busWrite),
      .busWru     (busWru),
      .busAddr    (busAddr),
      .regData    (regData),
      .devData    (devData),
      .wruData    (wruData),
      .devAckIn   (devAck),
      .busAckIn   (busAckInt),
      .devReq     (devReq),
      .busAck     (busAck),
      .busDataOut (busDataOut),
      .rq         (rq)
   );

   // Timeout watcher, owns the bus acknowledge
   ubaNxd #(
      .NxdTimeout (NxdTimeout)
   ) nxd (
      .clk       (clk),
      .rst       (rst),
      .rq        (rq),
      .busAckOut (busAckInt),
      .setNxd    (setNxd)
   );

   // Status reports raw pending lines
   ubaRegs regs (
      .clk       (clk),
      .rst       (rst),
      .rq        (rq),
      .busWrite  (busWrite),
      .busAddr   (busAddr),
      .busDataIn (busDataIn),
      .setNxd    (setNxd),
      .pend      (irq),
      .mask      (mask),
      .regData   (regData)
   );

   ubaWru wru (
      .rq      (rq),
      .irq     (irq),
      .mask    (mask),
      .wruData (wruData)
   );

endmodule

`default_nettype wire

// ==== verif/ubaTb.sv ====
`default_nettype none

module ubaTb;

   import ubaPkg::*;

   localparam int NxdTimeout     = 10;
   // Ordered tests need about 1500 cycles
   localparam int TestCycles     = 1500;
   localparam int WatchdogCycles = TestCycles * 8 / 3;

   logic     clk = 1'b0;
   logic     rst;
   logic     busReq;
   logic     busWrite;
   logic     busWru;
   ubaAddr_t busAddr;
   ubaData_t busDataIn;
   ubaData_t busDataOut;
   logic     busAck;
   logic     devReq;
   logic     devAck = 1'b0;
   ubaData_t devData = '0;
   ubaIrq_t  irq;

   // Mask as the master last wrote it
   ubaIrq_t  maskModel = '0;
   int       devDelay = 0;
   int       devWaited = 0;
   logic     regSel;
   logic     devSel;
   logic     unmapSel;

   uba #(.NxdTimeout(NxdTimeout)) dut (.*);

   always #10 clk = ~clk;

   // Expected target of the current cycle, from the address map
   assign regSel   = !busWru && (busAddr == UbaStatusAddr || busAddr == UbaMaskAddr);
   assign devSel   = !busWru && !regSel && busAddr >= DevBase && busAddr <= DevLast;
   assign unmapSel = !busWru && !regSel && !devSel;

   task automatic abortRun(input string line);
      $display("%s", line);
      $display("tests failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic flagMismatch(input string msg);
      abortRun($sformatf("mismatch at %0t: %s", $time, msg));
   endtask

   //////////////////////////////////////////////////////////////////////
   // Device model
   //////////////////////////////////////////////////////////////////////

   // Answers devDelay cycles after seeing devReq, holds until it drops
   always @(posedge clk)
   begin
      if (devReq && !devAck)
      begin
         if (devWaited >= devDelay)
         begin
            #2;
            devAck  = 1'b1;
            devData = busAddr[15:0] ^ 16'h5a5a;
         end
         else
            devWaited++;
      end
      else if (!devReq)
      begin
         #2;
         devAck    = 1'b0;
         devWaited = 0;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Protocol checks
   //////////////////////////////////////////////////////////////////////

   ackNeedsReq: assert property (@(posedge clk) disable iff (rst) busAck |-> busReq)
      else flagMismatch("busAck high without busReq");
   // Back-pressure, acknowledge held with the request
   ackHolds: assert property (@(posedge clk) disable iff (rst)
      ($past(busAck) && busReq) |-> busAck)
      else flagMismatch("busAck dropped while busReq held");
   // Register acknowledge exactly 2 cycles in
   regAckTiming: assert property (@(posedge clk) disable iff (rst)
      regSel |-> (busAck == (busReq && $past(busReq) && $past(busReq, 2))))
      else flagMismatch("register busAck not 2 cycles after busReq");
   // One cycle behind the first devAck, never without it
   devAckTiming: assert property (@(posedge clk) disable iff (rst)
      devSel |-> (busAck == (busReq && $past(busReq) && $past(devAck))))
      else flagMismatch("device busAck not 1 cycle after devAck");
   devReqDecode: assert property (@(posedge clk) disable iff (rst)
      devReq == (busReq && devSel))
      else flagMismatch("devReq does not follow the decode");
   noAckUnmapped: assert property (@(posedge clk) disable iff (rst) unmapSel |-> !busAck)
      else flagMismatch("busAck on an unmapped address");
   // WRU answered next cycle only if an enabled line is pending
   wruAckRule: assert property (@(posedge clk) disable iff (rst)
      busWru |-> (busAck == (busReq && $past(busReq) && ((irq & maskModel) != '0))))
      else flagMismatch("WRU busAck against the masked pending set");
   quietInReset: assert property (@(posedge clk) rst |-> (!busAck && !devReq))
      else flagMismatch("busAck or devReq high during reset");
   quietAfterReset: assert property (@(posedge clk) $fell(rst) |-> (!busAck && !devReq))
      else flagMismatch("busAck or devReq high right after reset");

   //////////////////////////////////////////////////////////////////////
   // Bus master
   //////////////////////////////////////////////////////////////////////

   function automatic ubaData_t statusWord(input logic nxd, input ubaIrq_t pend);
      return {nxd, 11'b0, pend};
   endfunction

   // Bit 3 first
   function automatic ubaData_t highestLine(input ubaIrq_t m);
      highestLine = 16'h0000;
      if (m[3])
         highestLine = 16'h0008;
      else if (m[2])
         highestLine = 16'h0004;
      else if (m[1])
         highestLine = 16'h0002;
      else if (m[0])
         highestLine = 16'h0001;
   endfunction

   // Held until busAck or for limit cycles, entered 2 units after an edge
   task automatic runCycle(input ubaAddr_t addr, input logic wr, input logic wru,
                           input ubaData_t wdata, input int limit,
                           output logic acked, output ubaData_t rdata);
      int n;
      n         = 0;
      acked     = 1'b0;
      rdata     = '0;
      busAddr   = addr;
      busWrite  = wr;
      busWru    = wru;
      busDataIn = wdata;
      busReq    = 1'b1;
      while (!acked && n < limit)
      begin
         // Outputs settled at the falling edge
         @(negedge clk);
         n++;
         if (busAck)
         begin
            acked = 1'b1;
            rdata = busDataOut;
         end
      end
      // Master may keep the request a little past busAck
      if (acked)
         repeat ($urandom_range(0, 2)) @(posedge clk);
      @(posedge clk);
      #2;
      busReq   = 1'b0;
      busWrite = 1'b0;
      busWru   = 1'b0;
      repeat (2) @(posedge clk);
      #2;
   endtask

   task automatic regWrite(input ubaAddr_t addr, input ubaData_t data);
      logic     acked;
      ubaData_t rdata;
      runCycle(addr, 1'b1, 1'b0, data, 10, acked, rdata);
      assert (acked) else abortRun("register write got no acknowledge");
      if (addr == UbaMaskAddr)
         maskModel = data[3:0];
   endtask

   task automatic regRead(input ubaAddr_t addr, input ubaData_t expected);
      logic     acked;
      ubaData_t rdata;
      runCycle(addr, 1'b0, 1'b0, '0, 10, acked, rdata);
      assert (acked) else abortRun("register read got no acknowledge");
      assert (rdata == expected)
         else flagMismatch($sformatf("read %h at %h, expected %h", rdata, addr, expected));
   endtask

   // No busAck, then sticky NXD set and write-1 cleared
   task automatic timeoutCycle(input ubaAddr_t addr);
      logic     acked;
      ubaData_t rdata;
      runCycle(addr, 1'b0, 1'b0, '0, NxdTimeout + 4, acked, rdata);
      assert (!acked) else abortRun("cycle acknowledged although it should time out");
      // Held request restarts the count, let it run out
      repeat (2 * NxdTimeout) @(posedge clk);
      #2;
      regRead(UbaStatusAddr, statusWord(1'b1, irq));
      regWrite(UbaStatusAddr, 16'h7fff);
      regRead(UbaStatusAddr, statusWord(1'b1, irq));
      regWrite(UbaStatusAddr, 16'h8000);
      regRead(UbaStatusAddr, statusWord(1'b0, irq));
   endtask

   //////////////////////////////////////////////////////////////////////
   // Ordered tests
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      ubaAddr_t    addr;
      ubaData_t    rdata;
      ubaData_t    wdata;
      ubaIrq_t     masked;
      logic        acked;

      void'($urandom(32'hb819_137d));
      rst       = 1'b1;
      busReq    = 1'b0;
      busWrite  = 1'b0;
      busWru    = 1'b0;
      busAddr   = '0;
      busDataIn = '0;
      irq       = '0;
      repeat (4) @(posedge clk);
      #2;
      rst = 1'b0;

      // Reset values
      regRead(UbaStatusAddr, statusWord(1'b0, irq));
      regRead(UbaMaskAddr, 16'h0000);

      // Mask read back, status mirrors irq
      for (int i = 0; i < 8; i++)
      begin
         wdata = ubaData_t'($urandom);
         regWrite(UbaMaskAddr, wdata);
         regRead(UbaMaskAddr, {12'h000, wdata[3:0]});
         irq = ubaIrq_t'($urandom_range(0, 15));
         regRead(UbaStatusAddr, statusWord(1'b0, irq));
      end

      // Random window addresses and device delays
      for (int i = 0; i < 20; i++)
      begin
         addr     = DevBase + ubaAddr_t'($urandom_range(0, 255));
         devDelay = $urandom_range(0, 6);
         runCycle(addr, 1'b0, 1'b0, '0, 20, acked, rdata);
         assert (acked) else abortRun("device read got no acknowledge");
         assert (rdata == (addr[15:0] ^ 16'h5a5a))
            else flagMismatch($sformatf("device read %h at %h", rdata, addr));
         runCycle(addr, 1'b1, 1'b0, ubaData_t'($urandom), 20, acked, rdata);
         assert (acked) else abortRun("device write got no acknowledge");
      end

      // Unmapped address, then a device slower than the timeout
      addr = 18'h1_0000 | ubaAddr_t'($urandom_range(0, 16'hffff));
      timeoutCycle(addr);
      devDelay = NxdTimeout + 10;
      timeoutCycle(DevBase + 18'h0_0040);
      devDelay = 0;

      // WRU against random irq and mask
      for (int i = 0; i < 16; i++)
      begin
         wdata = ubaData_t'($urandom);
         irq   = ubaIrq_t'($urandom_range(0, 15));
         // Every fourth round nothing enabled is pending
         if (i % 4 == 0)
            wdata[3:0] = ~irq;
         regWrite(UbaMaskAddr, wdata);
         masked = irq & wdata[3:0];
         runCycle(ubaAddr_t'($urandom), 1'b0, 1'b1, '0, 20, acked, rdata);
         if (masked != '0)
         begin
            assert (acked) else abortRun("WRU cycle with a pending interrupt got no acknowledge");
            assert (rdata == highestLine(masked))
               else flagMismatch($sformatf("WRU answer %h for masked %b", rdata, masked));
         end
         else
            assert (!acked) else abortRun("WRU cycle acknowledged with nothing pending");
      end

      $display("all tests passed");
      $finish;
   end

   // Watchdog
   initial
   begin
      repeat (WatchdogCycles) @(posedge clk);
      abortRun("watchdog expired before the tests finished");
   end

endmodule

`default_nettype wire

// ==== list.f ====
source/ubaPkg.sv
source/ubaReqIf.sv
source/ubaBusIf.sv
source/ubaNxd.sv
source/ubaRegs.sv
source/ubaWru.sv
source/uba.sv
verif/ubaTb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then decide from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module ubaTb -o ubaSim > sim.log 2>&1 \
   && ./obj_dir/ubaSim >> sim.log 2>&1
grep -q "tests failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "all tests passed" sim.log || { echo "FAIL, no pass line in sim.log"; exit 1; }
echo "PASS"
exit 0
